/* verilog.f */
common/keypad_pkg.sv
src/scan_timer.sv
keypad/keypad_scan_fsm.sv
keypad/keypad_debounce.sv
src/keypad_ctrl.sv
verification/keypad_ctrl_tb.sv

/* Makefile */
# Verilator build, run and lint for the keypad scanning controller

VERILATOR ?= verilator
TB_TOP    ?= keypad_ctrl_tb
RTL_TOP   ?= keypad_ctrl
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only -Wall
PASS_MSG  ?= All tests passed

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the simulation prints the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* verification/keypad_ctrl_tb.sv */
// Directed testbench for the keypad scanning controller.
// A keypad matrix model answers the row drive; tasks press keys and check the events.

module keypad_ctrl_tb;

  import keypad_pkg::*;

  localparam int scan_div        = 4;
  localparam int debounce_frames = 3;
  localparam int clk_period      = 100;
  localparam int num_keys        = num_rows * num_cols;
  localparam int frame_cycles    = num_rows * scan_div;
  localparam int hold_frames     = 6;
  // press or release lands at most one partial frame plus the debounce run later
  localparam int latency_cycles  = (debounce_frames + 1) * frame_cycles + 4;
  localparam int num_tests       = 5;
  localparam int watchdog_time   = num_tests * 50 * frame_cycles * clk_period;
  localparam int rand_seed       = 15732;

  logic                pclk;
  logic                reset;
  logic [num_cols-1:0] columns;
  logic [num_rows-1:0] rows;
  key_event_t          key_event;
  key_code_t           pressed_key;

  logic [num_keys-1:0] held_keys;
  key_event_t          event_q[$];
  int                  cycle_count = 0;

  keypad_ctrl #(
    .scan_div        (scan_div),
    .debounce_frames (debounce_frames)
  ) UUT (
    .pclk        (pclk),
    .reset       (reset),
    .columns     (columns),
    .rows        (rows),
    .key_event   (key_event),
    .pressed_key (pressed_key)
  );

  initial begin
    pclk = 1'b0;
    forever #(clk_period / 2) pclk = ~pclk;
  end

  // ------------------------------------------------------------------------
  // keypad matrix model and event capture
  // ------------------------------------------------------------------------
  // key index is row * num_cols + col
  function automatic logic [num_cols-1:0] column_levels(input logic [num_rows-1:0] drive,
                                                        input logic [num_keys-1:0] keys);
    logic [num_cols-1:0] cols;
    cols = '1;
    for (int r = 0; r < num_rows; r++) begin
      for (int c = 0; c < num_cols; c++) begin
        if (!drive[r] && keys[r * num_cols + c]) begin
          cols[c] = 1'b0;
        end
      end
    end
    return cols;
  endfunction

  initial begin
    columns = '1;
    forever begin
      @(negedge pclk);
      columns <= column_levels(rows, held_keys);
    end
  end

  // outputs read here still hold the previous cycle's value
  always @(posedge pclk) begin
    cycle_count <= cycle_count + 1;
    if (key_event.valid === 1'b1) begin
      event_q.push_back(key_event);
    end
  end

  // ------------------------------------------------------------------------
  // reporting and compare tasks
  // ------------------------------------------------------------------------
  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_event(input string name, input key_event_t got, input key_event_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_code(input string name, input key_code_t got, input key_code_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_rows(input string name, input logic [num_rows-1:0] got,
                            input logic [num_rows-1:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  initial begin
    #(watchdog_time);
    stop_with_failure($sformatf("watchdog expired after %0d time units", watchdog_time));
  end

  // ------------------------------------------------------------------------
  // stimulus helpers
  // ------------------------------------------------------------------------
  // telephone layout with star 0 hash on the bottom row
  function automatic key_code_t table_code(input int idx);
    case (idx)
      9:       return 8'h0A;
      10:      return 8'h00;
      11:      return 8'h0B;
      default: return key_code_t'(idx + 1);
    endcase
  endfunction

  function automatic logic [num_keys-1:0] key_mask(input int idx);
    return num_keys'(1) << idx;
  endfunction

  // row drive with only row r pulled low
  function automatic logic [num_rows-1:0] one_row_low(input int r);
    logic [num_rows-1:0] mask;
    mask    = '1;
    mask[r] = 1'b0;
    return mask;
  endfunction

  function automatic key_event_t make_event(input logic press, input key_code_t code);
    key_event_t ev;
    ev.valid = 1'b1;
    ev.press = press;
    ev.code  = code;
    return ev;
  endfunction

  task automatic set_keys(input logic [num_keys-1:0] mask);
    @(negedge pclk);
    held_keys <= mask;
  endtask

  task automatic hold_until(input int start, input int frames);
    while (cycle_count - start < frames * frame_cycles) begin
      @(negedge pclk);
    end
  endtask

  task automatic expect_event(input key_event_t exp, input int max_cycles);
    int         waited;
    key_event_t got;
    waited = 0;
    while (event_q.size() == 0) begin
      if (waited >= max_cycles) begin
        stop_with_failure($sformatf("no key event 0x%h seen within %0d cycles",
                                    exp, max_cycles));
      end
      @(negedge pclk);
      waited++;
    end
    got = event_q.pop_front();
    check_event("key_event", got, exp);
  endtask

  task automatic expect_no_event();
    key_event_t got;
    if (event_q.size() != 0) begin
      got = event_q.pop_front();
      stop_with_failure($sformatf("unexpected key event 0x%h (press %0b code 0x%h)",
                                  got, got.press, got.code));
    end
  endtask

  // apply a key set, wait for one event, then hold with no further events
  task automatic apply_and_expect(input logic [num_keys-1:0] mask, input key_event_t exp,
                                  input int frames);
    int        start;
    key_code_t shown;
    start = cycle_count;
    shown = exp.press ? exp.code : key_none;
    set_keys(mask);
    expect_event(exp, latency_cycles);
    check_code("pressed_key", pressed_key, shown);
    hold_until(start, frames);
    expect_no_event();
    check_code("pressed_key", pressed_key, shown);
  endtask

  task automatic pick_two_keys(output int a, output int b);
    a = int'($urandom % num_keys);
    b = (a + 1 + int'($urandom % (num_keys - 1))) % num_keys;
  endtask

  // ------------------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------------------
  task automatic wait_rows_change(input int max_cycles);
    logic [num_rows-1:0] prev;
    int                  waited;
    prev   = rows;
    waited = 0;
    while (rows === prev) begin
      if (waited >= max_cycles) begin
        stop_with_failure($sformatf("rows did not change within %0d cycles", max_cycles));
      end
      @(negedge pclk);
      waited++;
    end
  endtask

  task automatic reset_and_scan_order();
    check_rows("rows", rows, '1);
    check_code("pressed_key", pressed_key, key_none);
    wait_rows_change(5 * scan_div);
    check_rows("rows", rows, one_row_low(0));
    for (int r = 1; r < num_rows; r++) begin
      wait_rows_change(scan_div + 1);
      check_rows("rows", rows, one_row_low(r));
    end
  endtask

  task automatic press_release_every_key();
    int order [num_keys];
    int j;
    int tmp;
    for (int i = 0; i < num_keys; i++) begin
      order[i] = i;
    end
    // shuffle
    for (int i = num_keys - 1; i > 0; i--) begin
      j        = int'($urandom % (i + 1));
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    foreach (order[i]) begin
      apply_and_expect(key_mask(order[i]), make_event(1'b1, table_code(order[i])), hold_frames);
      apply_and_expect('0, make_event(1'b0, table_code(order[i])), hold_frames);
    end
  endtask

  task automatic short_press_ignored();
    int key;
    int frames;
    int first_len;
    int start;
    // random first length, the other length on the second trial
    first_len = int'($urandom % 2);
    for (int trial = 0; trial < 2; trial++) begin
      key    = int'($urandom % num_keys);
      frames = 1 + (first_len + trial) % 2;
      start  = cycle_count;
      set_keys(key_mask(key));
      // set_keys already spent one cycle of the hold
      repeat (frames * frame_cycles - 1) @(negedge pclk);
      set_keys('0);
      hold_until(start, frames + hold_frames);
      expect_no_event();
      check_code("pressed_key", pressed_key, key_none);
    end
  endtask

  task automatic two_keys_rejected();
    int a;
    int b;
    int start;
    pick_two_keys(a, b);
    start = cycle_count;
    set_keys(key_mask(a) | key_mask(b));
    hold_until(start, 10);
    expect_no_event();
    check_code("pressed_key", pressed_key, key_none);
    // letting go of one leaves a single readable key
    apply_and_expect(key_mask(b), make_event(1'b1, table_code(b)), hold_frames);
    apply_and_expect('0, make_event(1'b0, table_code(b)), hold_frames);
  endtask

  task automatic direct_key_change();
    int a;
    int b;
    int start;
    pick_two_keys(a, b);
    apply_and_expect(key_mask(a), make_event(1'b1, table_code(a)), hold_frames);
    start = cycle_count;
    set_keys(key_mask(b));
    expect_event(make_event(1'b0, table_code(a)), latency_cycles);
    // new key follows one frame after the release
    expect_event(make_event(1'b1, table_code(b)), frame_cycles + 4);
    check_code("pressed_key", pressed_key, table_code(b));
    hold_until(start, hold_frames);
    expect_no_event();
    apply_and_expect('0, make_event(1'b0, table_code(b)), hold_frames);
  endtask

  initial begin
    void'($urandom(rand_seed));
    reset     = 1'b1;
    held_keys = '0;
    repeat (4) @(posedge pclk);
    @(negedge pclk);
    reset = 1'b0;

    reset_and_scan_order();
    press_release_every_key();
    short_press_ignored();
    two_keys_rejected();
    direct_key_change();

    $display("All tests passed");
    $finish;
  end

endmodule

/* src/keypad_ctrl.sv */
// Top level of the keypad scanning controller.
// Connects the dwell timer, the row-scan FSM and the debouncer.

module keypad_ctrl #(
  parameter int unsigned scan_div        = 16,
  parameter int unsigned debounce_frames = 3
) (
  input  logic                            pclk,
  input  logic                            reset,
  input  logic [keypad_pkg::num_cols-1:0] columns,
  output logic [keypad_pkg::num_rows-1:0] rows,
  output keypad_pkg::key_event_t          key_event,
  output keypad_pkg::key_code_t           pressed_key
);

  import keypad_pkg::*;

  logic         row_tick;
  scan_sample_t sample;

  // ------------------------------------------------------------------------
  // scan rate
  // ------------------------------------------------------------------------
  scan_timer #(
    .scan_div (scan_div)
  ) u_scan_timer (
    .pclk     (pclk),
    .reset    (reset),
    .row_tick (row_tick)
  );

  // ------------------------------------------------------------------------
  // row drive and column capture
  // ------------------------------------------------------------------------
  keypad_scan_fsm u_scan_fsm (
    .pclk     (pclk),
    .reset    (reset),
    .row_tick (row_tick),
    .columns  (columns),
    .rows     (rows),
    .sample   (sample)
  );

  // ------------------------------------------------------------------------
  // decode and debounce
  // ------------------------------------------------------------------------
  keypad_debounce #(
    .debounce_frames (debounce_frames)
  ) u_debounce (
    .pclk        (pclk),
    .reset       (reset),
    .sample      (sample),
    .key_event   (key_event),
    .pressed_key (pressed_key)
  );

endmodule

/* keypad/keypad_debounce.sv */
// Frame decoder and debouncer for the keypad scan.
// Builds one key code per scan frame and reports stable changes as press/release events.

module keypad_debounce #(
  parameter int unsigned debounce_frames = 3
) (
  input  logic                     pclk,
  input  logic                     reset,
  input  keypad_pkg::scan_sample_t sample,
  output keypad_pkg::key_event_t   key_event,
  output keypad_pkg::key_code_t    pressed_key
);

  import keypad_pkg::*;

  localparam int cnt_w = $clog2(debounce_frames + 1);
  localparam logic [cnt_w-1:0] cnt_max = cnt_w'(debounce_frames);

  // frame accumulation
  logic      acc_hit;
  logic      acc_bad;
  key_code_t acc_code;

  logic      samp_any;
  logic      samp_bad;
  key_code_t samp_code;
  logic      cur_hit;
  logic      cur_bad;
  key_code_t cur_code;
  key_code_t frame_code;

  // stability tracking
  logic [cnt_w-1:0] stable_cnt;
  logic [cnt_w-1:0] cnt_nxt;
  key_code_t        last_code;
  key_code_t        held_key;
  logic             accept;

  // ------------------------------------------------------------------------
  // merge this sample into the running frame result
  // ------------------------------------------------------------------------
  always_comb begin
    samp_any  = |(~sample.columns);
    samp_code = key_code(sample.row, ~sample.columns);
    // more than one column low on a row
    samp_bad  = samp_any && (samp_code == key_none);

    cur_hit  = acc_hit | samp_any;
    // a second row with a key also spoils the frame
    cur_bad  = acc_bad | samp_bad | (acc_hit & samp_any);
    cur_code = acc_hit ? acc_code : samp_code;

    frame_code = cur_hit ? cur_code : key_none;

    // count 0 means nothing to compare against
    if ((stable_cnt != '0) && (frame_code == last_code)) begin
      cnt_nxt = (stable_cnt == cnt_max) ? stable_cnt : stable_cnt + 1'b1;
    end else begin
      cnt_nxt = cnt_w'(1);
    end

    accept = (cnt_nxt == cnt_max) && (frame_code != held_key);
  end

  // ------------------------------------------------------------------------
  // per-frame judgement
  // ------------------------------------------------------------------------
  always_ff @(posedge pclk) begin
    if (reset) begin
      acc_hit         <= 1'b0;
      acc_bad         <= 1'b0;
      stable_cnt      <= '0;
      held_key        <= key_none;
      key_event.valid <= 1'b0;
    end else begin
      key_event.valid <= 1'b0;
      if (sample.valid) begin
        if (sample.frame_end) begin
          acc_hit <= 1'b0;
          acc_bad <= 1'b0;
          if (cur_bad) begin
            stable_cnt <= '0;
          end else begin
            stable_cnt <= cnt_nxt;
            last_code  <= frame_code;
            if (accept) begin
              key_event.valid <= 1'b1;
              // old key goes first, new one follows a frame later
              if (held_key != key_none) begin
                key_event.press <= 1'b0;
                key_event.code  <= held_key;
                held_key        <= key_none;
              end else begin
                key_event.press <= 1'b1;
                key_event.code  <= frame_code;
                held_key        <= frame_code;
              end
            end
          end
        end else begin
          acc_hit  <= cur_hit;
          acc_bad  <= cur_bad;
          acc_code <= cur_code;
        end
      end
    end
  end

  assign pressed_key = held_key;

endmodule

/* keypad/keypad_scan_fsm.sv */
// Row-scan FSM for the keypad matrix.
// Drives one row low per dwell and captures that row's columns on the next row_tick.

module keypad_scan_fsm (
  input  logic                           pclk,
  input  logic                           reset,
  input  logic                           row_tick,
  input  logic [keypad_pkg::num_cols-1:0] columns,
  output logic [keypad_pkg::num_rows-1:0] rows,
  output keypad_pkg::scan_sample_t        sample
);

  import keypad_pkg::*;

  typedef enum logic [2:0] {
    idle = 3'b000,
    row0 = 3'b001,
    row1 = 3'b010,
    row2 = 3'b011,
    row3 = 3'b100
  } state_t;

  state_t              state;
  state_t              state_nxt;
  logic [row_w-1:0]    cur_row;
  logic [row_w-1:0]    nxt_row;
  logic [num_rows-1:0] rows_nxt;

  function automatic logic [row_w-1:0] row_of(input state_t st);
    logic [row_w-1:0] r;
    case (st)
      row1:    r = row_w'(1);
      row2:    r = row_w'(2);
      row3:    r = row_w'(3);
      default: r = row_w'(0);
    endcase
    return r;
  endfunction

  // ------------------------------------------------------------------------
  // next state, steps only when the timer ticks
  // ------------------------------------------------------------------------
  always_comb begin
    case (state)
      idle:    state_nxt = row0;
      row0:    state_nxt = row1;
      row1:    state_nxt = row2;
      row2:    state_nxt = row3;
      row3:    state_nxt = row0;
      default: state_nxt = idle;
    endcase
    cur_row  = row_of(state);
    nxt_row  = row_of(state_nxt);
    // active low, one row at a time
    rows_nxt = ~(num_rows'(1) << nxt_row);
  end

  // ------------------------------------------------------------------------
  // state, row drive and column capture
  // ------------------------------------------------------------------------
  always_ff @(posedge pclk) begin
    if (reset) begin
      state        <= idle;
      rows         <= '1;
      sample.valid <= 1'b0;
    end else begin
      sample.valid <= 1'b0;
      if (row_tick) begin
        state <= state_nxt;
        rows  <= rows_nxt;
        // columns belong to the row driven during the dwell just ended
        if (state != idle) begin
          sample.valid     <= 1'b1;
          sample.row       <= cur_row;
          sample.columns   <= columns;
          sample.frame_end <= (cur_row == row_w'(num_rows - 1));
        end
      end
    end
  end

endmodule

/* src/scan_timer.sv */
// Row dwell timer for the keypad scan.
// Emits a single-cycle row_tick every scan_div pclk cycles.

module scan_timer #(
  parameter int unsigned scan_div = 16
) (
  input  logic pclk,
  input  logic reset,
  output logic row_tick
);

  localparam int cnt_w = $clog2(scan_div);
  localparam logic [cnt_w-1:0] reload = cnt_w'(scan_div - 1);

  logic [cnt_w-1:0] count;

  // ------------------------------------------------------------------------
  // down-counter, reloads after hitting zero
  // ------------------------------------------------------------------------
  always_ff @(posedge pclk) begin
    if (reset) begin
      count <= reload;
    end else if (count == '0) begin
      count <= reload;
    end else begin
      count <= count - 1'b1;
    end
  end

  // tick on the terminal count
  assign row_tick = (count == '0);

endmodule

/* common/keypad_pkg.sv */
// Shared widths, key codes and struct types for the keypad scanning controller.
// Modules import this package inside their bodies and use scoped names in port lists.

package keypad_pkg;

  localparam int num_rows = 4;
  localparam int num_cols = 3;
  localparam int row_w    = $clog2(num_rows);

  typedef logic [7:0] key_code_t;

  // codes for the bottom row, digits 1..9 map straight to their value
  localparam key_code_t key_zero = 8'h00;
  localparam key_code_t key_star = 8'h0A;
  localparam key_code_t key_hash = 8'h0B;
  localparam key_code_t key_none = 8'hFF;

  // one row's column reading, as taken by the scan FSM
  typedef struct packed {
    logic                valid;
    logic [row_w-1:0]    row;
    logic [num_cols-1:0] columns;
    logic                frame_end;
  } scan_sample_t;

  typedef struct packed {
    logic      valid;
    logic      press;
    key_code_t code;
  } key_event_t;

  // code of one key from its row and a one-hot mask of low columns
  function automatic key_code_t key_code(input logic [row_w-1:0]    row,
                                         input logic [num_cols-1:0] col_low);
    key_code_t  code;
    logic [1:0] col;
    logic       one_hot;
    one_hot = 1'b1;
    case (col_low)
      3'b001:  col = 2'd0;
      3'b010:  col = 2'd1;
      3'b100:  col = 2'd2;
      default: begin
        col     = 2'd0;
        one_hot = 1'b0;
      end
    endcase
    if (!one_hot) begin
      code = key_none;
    end else if (row == row_w'(num_rows - 1)) begin
      code = (col == 2'd0) ? key_star : ((col == 2'd1) ? key_zero : key_hash);
    end else begin
      code = key_code_t'(row * num_cols + col + 1);
    end
    return code;
  endfunction

endpackage
